/* common/gem_csc_pkg.sv */
// gem_csc_pkg: shared coordinate types, detector ranges, bus structs and table formulas
package gem_csc_pkg;

   typedef logic [7:0] pad_t;      // gem pad 0-191
   typedef logic [2:0] roll_t;     // gem eta partition 0-7
   typedef logic [2:0] clsize_t;   // 0 means one pad
   typedef logic [9:0] xky_t;      // eighth-strip key
   typedef logic [6:0] wire_t;     // csc wiregroup

   localparam int    PAD_DEPTH     = 256;   // full pad address space
   localparam int    ROLL_DEPTH    = 8;
   localparam int    MAX_PAD       = 191;
   localparam wire_t MAX_WIRE      = 7'd47;
   localparam xky_t  ME1B_XKY_MIN  = 10'd0;
   localparam xky_t  ME1B_XKY_MAX  = 10'd511;
   localparam xky_t  ME1A_XKY_MIN  = 10'd512;
   localparam xky_t  ME1A_XKY_MAX  = 10'd895;
   localparam xky_t  ME1B_XKY_NONE = 10'd896;  // me1b window when cluster sits in me1a
   localparam xky_t  ME1A_XKY_NONE = 10'd224;  // me1a window when cluster sits in me1b
   localparam roll_t ME1A_ROLL     = 3'd7;     // only this roll reaches me1a

   typedef struct packed {
      logic        vpf;
      roll_t       roll;
      pad_t        pad;
      clsize_t     size;
      logic [13:0] raw;   // untouched cluster word
   } gem_cluster_t;

   typedef struct packed {
      logic       evenchamber;
      logic       match_en;
      logic       me1a_en;
      logic       me1b_en;
      logic [4:0] delta_hs;     // window in halfstrips
      logic [2:0] delta_wire;   // window in wiregroups
   } match_cfg_t;

   typedef struct packed { xky_t lo; xky_t hi; } xky_pair_t;
   typedef struct packed { wire_t lo; wire_t hi; } wire_pair_t;

   typedef struct packed {
      wire_t wire_lo, wire_hi, wire_mi;
      xky_t  me1b_lo, me1b_hi, me1b_mi;
      xky_t  me1a_lo, me1a_hi, me1a_mi;
   } csc_window_t;

   // stand-in mapping, even chambers run mirrored in pad
   function automatic xky_t pad_to_me1b_xky(input logic even, input int p);
      int pc;
      pc = (p > MAX_PAD) ? MAX_PAD : p;   // top of address space repeats pad 191
      return xky_t'(even ? (8 * (MAX_PAD - pc)) / 3 : (8 * pc) / 3);
   endfunction

   function automatic xky_t pad_to_me1a_xky(input logic even, input int p);
      int pc;
      pc = (p > MAX_PAD) ? MAX_PAD : p;
      return xky_t'(even ? 512 + 2 * (MAX_PAD - pc) : 512 + 2 * pc);
   endfunction

   function automatic wire_t roll_to_wire_lo(input logic even, input int r);
      return wire_t'(even ? 6 * (7 - r) : 6 * r);
   endfunction

   function automatic wire_t roll_to_wire_hi(input logic even, input int r);
      int w;
      w = int'(roll_to_wire_lo(even, r)) + 7;
      return (w > int'(MAX_WIRE)) ? MAX_WIRE : wire_t'(w);   // last roll runs off the chamber
   endfunction

endpackage

/* hw/gem_lut/pad_xky_lut.sv */
// pad_xky_lut: registered four-read rom from gem pad to me1a and me1b eighth-strip keys
`timescale 1ns/1ps

module pad_xky_lut (
   input  logic                  logic_clock,
   input  logic                  even,        // bank select, even chamber
   input  gem_csc_pkg::pad_t     adr_lo,      // lowest pad of cluster
   input  gem_csc_pkg::pad_t     adr_hi,      // highest pad of cluster
   output gem_csc_pkg::xky_pair_t me1a_keys,
   output gem_csc_pkg::xky_pair_t me1b_keys
);
   import gem_csc_pkg::*;

   // one bank per region and chamber parity
   xky_t me1a_odd  [PAD_DEPTH];
   xky_t me1a_even [PAD_DEPTH];
   xky_t me1b_odd  [PAD_DEPTH];
   xky_t me1b_even [PAD_DEPTH];

   // contents fixed for the chamber type
   initial begin
      for (int i = 0; i < PAD_DEPTH; i++) begin
         me1a_odd[i]  = pad_to_me1a_xky(1'b0, i);
         me1a_even[i] = pad_to_me1a_xky(1'b1, i);
         me1b_odd[i]  = pad_to_me1b_xky(1'b0, i);
         me1b_even[i] = pad_to_me1b_xky(1'b1, i);
      end
   end

   // two reads per bank, same shape as a dual port block ram
   always_ff @(posedge logic_clock) begin
      if (even) begin
         me1a_keys.lo <= me1a_even[adr_lo];
         me1a_keys.hi <= me1a_even[adr_hi];
         me1b_keys.lo <= me1b_even[adr_lo];
         me1b_keys.hi <= me1b_even[adr_hi];
      end else begin
         me1a_keys.lo <= me1a_odd[adr_lo];
         me1a_keys.hi <= me1a_odd[adr_hi];
         me1b_keys.lo <= me1b_odd[adr_lo];
         me1b_keys.hi <= me1b_odd[adr_hi];
      end
   end

   // note: even banks count down in pad, so lo key can come out above hi key
   //       the window block sorts them afterwards

endmodule

/* hw/gem_lut/roll_wire_lut.sv */
// roll_wire_lut: registered rom from gem roll to the low and high csc wiregroup
`timescale 1ns/1ps

module roll_wire_lut (
   input  logic                    logic_clock,
   input  logic                    even,       // bank select
   input  gem_csc_pkg::roll_t      roll,
   output gem_csc_pkg::wire_pair_t wire_keys
);
   import gem_csc_pkg::*;

   wire_t lo_odd  [ROLL_DEPTH];
   wire_t lo_even [ROLL_DEPTH];
   wire_t hi_odd  [ROLL_DEPTH];
   wire_t hi_even [ROLL_DEPTH];

   initial begin
      for (int i = 0; i < ROLL_DEPTH; i++) begin
         lo_odd[i]  = roll_to_wire_lo(1'b0, i);
         lo_even[i] = roll_to_wire_lo(1'b1, i);
         hi_odd[i]  = roll_to_wire_hi(1'b0, i);
         hi_even[i] = roll_to_wire_hi(1'b1, i);
      end
   end

   // one cycle read, lines up with the pad table
   always_ff @(posedge logic_clock) begin
      if (even) begin
         wire_keys.lo <= lo_even[roll];
         wire_keys.hi <= hi_even[roll];
      end else begin
         wire_keys.lo <= lo_odd[roll];
         wire_keys.hi <= hi_odd[roll];
      end
   end

endmodule

/* hw/cluster_match_ctrl.sv */
// cluster_match_ctrl: delays the cluster to the table latency and decides region and valid
`timescale 1ns/1ps

module cluster_match_ctrl (
   input  logic                      logic_clock,
   input  logic                      rst,
   input  gem_csc_pkg::match_cfg_t   cfg,
   input  gem_csc_pkg::gem_cluster_t cluster_in,
   output gem_csc_pkg::gem_cluster_t cluster_out,
   output logic                      in_me1a,   // 1 me1a, 0 me1b
   output logic                      valid
);
   import gem_csc_pkg::*;

   gem_cluster_t cluster_q;   // aligned with table read data

   always_ff @(posedge logic_clock) begin
      if (rst) begin
         cluster_q <= '0;
      end else begin
         cluster_q <= cluster_in;   // new cluster every clock
      end
   end

   assign cluster_out = cluster_q;

   // me1a only reachable from the last roll, and only if enabled
   assign in_me1a = (cluster_q.roll == ME1A_ROLL) && cfg.me1a_en;

   // disabled region turns the cluster invalid
   assign valid = cluster_q.vpf
                  && cfg.match_en
                  && (cfg.me1b_en || in_me1a);

   // roll 7 with me1a off falls back to me1b
   // and then needs me1b_en like any other roll

endmodule

/* hw/xky_window.sv */
// xky_window: sorts, widens, clamps and centers the me1a and me1b eighth-strip windows
`timescale 1ns/1ps

module xky_window (
   input  gem_csc_pkg::xky_pair_t me1a_keys,   // raw table pair
   input  gem_csc_pkg::xky_pair_t me1b_keys,
   input  logic [4:0]             delta_hs,    // halfstrip window
   input  logic                   in_me1a,
   output gem_csc_pkg::xky_t      me1a_lo,
   output gem_csc_pkg::xky_t      me1a_hi,
   output gem_csc_pkg::xky_t      me1a_mi,
   output gem_csc_pkg::xky_t      me1b_lo,
   output gem_csc_pkg::xky_t      me1b_hi,
   output gem_csc_pkg::xky_t      me1b_mi
);
   import gem_csc_pkg::*;

   // widen downward, never below the region floor
   function automatic xky_t widen_lo(input xky_t k, input xky_t d, input xky_t floor_k);
      return (k > floor_k + d) ? k - d : floor_k;
   endfunction

   // widen upward, never above the region ceiling
   function automatic xky_t widen_hi(input xky_t k, input xky_t d, input xky_t ceil_k);
      return (k + d > ceil_k) ? ceil_k : k + d;
   endfunction

   // rounds up when either end is odd
   function automatic xky_t midpoint(input xky_t lo, input xky_t hi);
      return {1'b0, lo[9:1]} + {1'b0, hi[9:1]} + xky_t'(lo[0] | hi[0]);
   endfunction

   xky_t delta_xky;                   // 4 eighth-strips per halfstrip
   xky_t me1a_min, me1a_max;          // sorted pair
   xky_t me1b_min, me1b_max;

   assign delta_xky = {3'b000, delta_hs, 2'b00};

   // even chambers read the table backwards
   assign me1a_min = (me1a_keys.lo < me1a_keys.hi) ? me1a_keys.lo : me1a_keys.hi;
   assign me1a_max = (me1a_keys.lo > me1a_keys.hi) ? me1a_keys.lo : me1a_keys.hi;
   assign me1b_min = (me1b_keys.lo < me1b_keys.hi) ? me1b_keys.lo : me1b_keys.hi;
   assign me1b_max = (me1b_keys.lo > me1b_keys.hi) ? me1b_keys.lo : me1b_keys.hi;

   // region not hit gets its none code
   assign me1b_lo = in_me1a ? ME1B_XKY_NONE : widen_lo(me1b_min, delta_xky, ME1B_XKY_MIN);
   assign me1b_hi = in_me1a ? ME1B_XKY_NONE : widen_hi(me1b_max, delta_xky, ME1B_XKY_MAX);
   assign me1a_lo = in_me1a ? widen_lo(me1a_min, delta_xky, ME1A_XKY_MIN) : ME1A_XKY_NONE;
   assign me1a_hi = in_me1a ? widen_hi(me1a_max, delta_xky, ME1A_XKY_MAX) : ME1A_XKY_NONE;

   assign me1b_mi = midpoint(me1b_lo, me1b_hi);   // 896 when in me1a
   assign me1a_mi = midpoint(me1a_lo, me1a_hi);   // 224 when in me1b

endmodule

/* hw/wire_window.sv */
// wire_window: sorts, widens, clamps and centers the wiregroup matching window
`timescale 1ns/1ps

module wire_window (
   input  gem_csc_pkg::wire_pair_t wire_keys,    // raw table pair
   input  logic [2:0]              delta_wire,   // window in wiregroups
   output gem_csc_pkg::wire_t      lo,
   output gem_csc_pkg::wire_t      hi,
   output gem_csc_pkg::wire_t      mi
);
   import gem_csc_pkg::*;

   wire_t w_min, w_max;
   wire_t dw;

   assign dw = {4'b0000, delta_wire};

   // guard against a swapped pair
   assign w_min = (wire_keys.lo < wire_keys.hi) ? wire_keys.lo : wire_keys.hi;
   assign w_max = (wire_keys.lo > wire_keys.hi) ? wire_keys.lo : wire_keys.hi;

   assign lo = (w_min > dw) ? w_min - dw : '0;                 // floor at wiregroup 0
   assign hi = (w_max + dw > MAX_WIRE) ? MAX_WIRE : w_max + dw; // ceiling at 47, no overflow

   // same rounding as the strip midpoints
   assign mi = {1'b0, lo[6:1]} + {1'b0, hi[6:1]} + wire_t'(lo[0] | hi[0]);

endmodule

/* hw/cluster_to_csc_top.sv */
// cluster_to_csc_top: gem cluster to csc wiregroup and eighth-strip windows for one me1/1 chamber
`timescale 1ns/1ps

module cluster_to_csc_top (
   input  logic                      logic_clock,
   input  logic                      rst,
   input  gem_csc_pkg::match_cfg_t   cfg,          // quasi-static
   input  gem_csc_pkg::gem_cluster_t cluster_in,
   output gem_csc_pkg::csc_window_t  win,
   output gem_csc_pkg::gem_cluster_t cluster_out,
   output logic                      in_me1a,
   output logic                      valid
);
   import gem_csc_pkg::*;

   pad_t       pad_lo, pad_hi;      // table addresses
   xky_pair_t  me1a_keys, me1b_keys;
   wire_pair_t wire_keys;

   // idle cycles read address 0
   assign pad_lo = cluster_in.vpf ? cluster_in.pad : '0;
   assign pad_hi = cluster_in.vpf ? cluster_in.pad + pad_t'(cluster_in.size) : '0;

   pad_xky_lut u_pad_lut (
      .logic_clock (logic_clock),
      .even        (cfg.evenchamber),
      .adr_lo      (pad_lo),
      .adr_hi      (pad_hi),
      .me1a_keys   (me1a_keys),
      .me1b_keys   (me1b_keys)
   );

   roll_wire_lut u_roll_lut (
      .logic_clock (logic_clock),
      .even        (cfg.evenchamber),
      .roll        (cluster_in.roll),
      .wire_keys   (wire_keys)
   );

   cluster_match_ctrl u_ctrl (
      .logic_clock (logic_clock),
      .rst         (rst),
      .cfg         (cfg),
      .cluster_in  (cluster_in),
      .cluster_out (cluster_out),
      .in_me1a     (in_me1a),
      .valid       (valid)
   );

   xky_window u_xky_win (
      .me1a_keys (me1a_keys),
      .me1b_keys (me1b_keys),
      .delta_hs  (cfg.delta_hs),
      .in_me1a   (in_me1a),
      .me1a_lo   (win.me1a_lo),
      .me1a_hi   (win.me1a_hi),
      .me1a_mi   (win.me1a_mi),
      .me1b_lo   (win.me1b_lo),
      .me1b_hi   (win.me1b_hi),
      .me1b_mi   (win.me1b_mi)
   );

   wire_window u_wire_win (
      .wire_keys  (wire_keys),
      .delta_wire (cfg.delta_wire),
      .lo         (win.wire_lo),
      .hi         (win.wire_hi),
      .mi         (win.wire_mi)
   );

endmodule

/* sim/cluster_to_csc_props.sv */
// cluster_to_csc_props: bound assertions on the range and gating rules of the top level
`timescale 1ns/1ps

module cluster_to_csc_props (
   input logic                     logic_clock,
   input logic                     rst,
   input gem_csc_pkg::match_cfg_t  cfg,
   input gem_csc_pkg::csc_window_t win,
   input logic                     in_me1a,
   input logic                     valid
);
   import gem_csc_pkg::*;

   // no output without the global match enable
   valid_needs_match_en : assert property (@(posedge logic_clock) disable iff (rst)
      valid |-> cfg.match_en)
      else $error("valid high while match_en is low");

   // me1a cluster leaves the me1b window empty
   me1b_none_in_me1a : assert property (@(posedge logic_clock) disable iff (rst)
      in_me1a |-> (win.me1b_lo == ME1B_XKY_NONE))
      else $error("me1b lo is %0d while in_me1a is high", win.me1b_lo);

   wire_window_order : assert property (@(posedge logic_clock) disable iff (rst)
      (win.wire_hi <= MAX_WIRE) && (win.wire_lo <= win.wire_hi))   // 0..47 and ordered
      else $error("wire window %0d..%0d out of range", win.wire_lo, win.wire_hi);

endmodule

bind cluster_to_csc_top cluster_to_csc_props props0 (
   .logic_clock (logic_clock),
   .rst         (rst),
   .cfg         (cfg),
   .win         (win),
   .in_me1a     (in_me1a),
   .valid       (valid)
);

/* sim/cluster_to_csc_tb.sv */
// cluster_to_csc_tb: replays golden vectors through the cluster to csc top and checks every cycle
`timescale 1ns/1ps

module cluster_to_csc_tb;
   import gem_csc_pkg::*;

   localparam int    CLK_PERIOD   = 8;
   localparam int    RESET_CYCLES = 3;
   localparam string GOLDEN_FILE  = "sim/cluster_to_csc_golden.txt";

   logic         logic_clock = 1'b0;
   logic         rst;
   match_cfg_t   cfg;
   gem_cluster_t cluster_in;
   csc_window_t  win;
   gem_cluster_t cluster_out;
   logic         in_me1a;
   logic         valid;

   // vectors, one entry per golden line
   match_cfg_t   cfg_q[$];
   gem_cluster_t clu_q[$];
   csc_window_t  exp_win[$];
   logic         exp_ina[$];
   logic         exp_val[$];
   int           n_lines = 0;
   logic         vectors_loaded = 1'b0;   // releases the watchdog

   cluster_to_csc_top dut0 (
      .logic_clock (logic_clock),
      .rst         (rst),
      .cfg         (cfg),
      .cluster_in  (cluster_in),
      .win         (win),
      .cluster_out (cluster_out),
      .in_me1a     (in_me1a),
      .valid       (valid)
   );

   always #(CLK_PERIOD / 2) logic_clock = ~logic_clock;   // 8 ns period

   task automatic stop_run();
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED time=%0t signal=%s got=%0d expected=%0d", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic load_vectors();
      int         fd;
      int         cnt;
      int         line_no;
      int         f [22];
      string      line;
      match_cfg_t c;
      csc_window_t w;
      line_no = 0;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         $display("cannot open the golden vector file %s", GOLDEN_FILE);
         stop_run();
      end
      while ($fgets(line, fd) != 0) begin
         line_no++;
         cnt = $sscanf(line,
                       "%d %d %d %d %d %d %d %d %d %d %h %d %d %d %d %d %d %d %d %d %d %d",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                       f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                       f[20], f[21]);
         if (cnt == 22) begin
            c.evenchamber = 1'(f[0]);
            c.match_en    = 1'(f[1]);
            c.me1a_en     = 1'(f[2]);
            c.me1b_en     = 1'(f[3]);
            c.delta_hs    = 5'(f[4]);
            c.delta_wire  = 3'(f[5]);
            cfg_q.push_back(c);
            clu_q.push_back({1'(f[6]), roll_t'(f[7]), pad_t'(f[8]), clsize_t'(f[9]), 14'(f[10])});
            w = {wire_t'(f[11]), wire_t'(f[12]), wire_t'(f[13]),
                 xky_t'(f[14]), xky_t'(f[15]), xky_t'(f[16]),
                 xky_t'(f[17]), xky_t'(f[18]), xky_t'(f[19])};
            exp_win.push_back(w);
            exp_ina.push_back(1'(f[20]));
            exp_val.push_back(1'(f[21]));
         end else if (cnt > 0) begin   // comment and blank lines give no fields
            $display("golden line %0d holds %0d fields where 22 are needed", line_no, cnt);
            stop_run();
         end
      end
      $fclose(fd);
      n_lines = cfg_q.size();
      if (n_lines == 0) begin
         $display("the golden vector file holds no vectors");
         stop_run();
      end
   endtask

   task automatic drive_line(input int n);
      cfg        = cfg_q[n];
      cluster_in = clu_q[n];
   endtask

   // results of line n, one rising edge after it was driven
   task automatic check_line(input int n);
      csc_window_t w;
      w = exp_win[n];
      check_value("win.wire_lo", 32'(win.wire_lo), 32'(w.wire_lo));
      check_value("win.wire_hi", 32'(win.wire_hi), 32'(w.wire_hi));
      check_value("win.wire_mi", 32'(win.wire_mi), 32'(w.wire_mi));
      check_value("win.me1b_lo", 32'(win.me1b_lo), 32'(w.me1b_lo));
      check_value("win.me1b_hi", 32'(win.me1b_hi), 32'(w.me1b_hi));
      check_value("win.me1b_mi", 32'(win.me1b_mi), 32'(w.me1b_mi));
      check_value("win.me1a_lo", 32'(win.me1a_lo), 32'(w.me1a_lo));
      check_value("win.me1a_hi", 32'(win.me1a_hi), 32'(w.me1a_hi));
      check_value("win.me1a_mi", 32'(win.me1a_mi), 32'(w.me1a_mi));
      check_value("in_me1a", 32'(in_me1a), 32'(exp_ina[n]));
      check_value("valid", 32'(valid), 32'(exp_val[n]));
      check_value("cluster_out", 32'(cluster_out), 32'(clu_q[n]));   // plain one cycle echo
   endtask

   initial begin : watchdog
      wait (vectors_loaded);
      #((n_lines + 20) * CLK_PERIOD);
      $display("simulation did not finish within the time allowed for the vectors");
      stop_run();
   end

   initial begin : stimulus
      rst        = 1'b1;
      cfg        = '0;
      cluster_in = '0;
      load_vectors();
      vectors_loaded = 1'b1;
      @(negedge logic_clock);
      cfg             = cfg_q[0];   // busy inputs while reset holds
      cfg.match_en    = 1'b1;
      cfg.me1a_en     = 1'b1;
      cluster_in      = clu_q[0];
      cluster_in.vpf  = 1'b1;
      cluster_in.roll = ME1A_ROLL;   // me1a cluster, a missed reset shows on in_me1a too
      repeat (RESET_CYCLES) @(posedge logic_clock);
      @(negedge logic_clock);
      rst = 1'b0;
      check_value("valid after reset", 32'(valid), 32'd0);
      check_value("in_me1a after reset", 32'(in_me1a), 32'd0);
      check_value("cluster_out after reset", 32'(cluster_out), 32'd0);
      drive_line(0);
      for (int n = 1; n <= n_lines; n++) begin
         @(negedge logic_clock);
         check_line(n - 1);
         if (n < n_lines) drive_line(n);   // back to back
      end
      $display("Regression passed");
      $finish;
   end

endmodule

/* sim/cluster_to_csc_golden.txt */
# cfg: even match_en me1a_en me1b_en delta_hs delta_wire | cluster: vpf roll pad size raw(hex)
# expected: wire_lo wire_hi wire_mi me1b_lo me1b_hi me1b_mi me1a_lo me1a_hi me1a_mi in_me1a valid
0 1 1 1 0 0 1 2 30 0 1a2b 12 19 16 80 80 80 224 224 224 0 1
1 1 1 1 0 0 1 2 30 0 0001 30 37 34 429 429 429 224 224 224 0 1
0 1 1 1 0 0 1 0 100 0 3fff 0 7 4 266 266 266 224 224 224 0 1
1 1 1 1 0 0 1 5 100 0 0abc 12 19 16 242 242 242 224 224 224 0 1
0 1 1 1 0 0 1 1 10 5 0123 6 13 10 26 40 33 224 224 224 0 1
1 1 1 1 0 0 1 1 10 5 0456 36 43 40 469 482 476 224 224 224 0 1
0 1 1 1 0 0 1 3 188 7 0789 18 25 22 501 509 505 224 224 224 0 1
1 1 1 1 0 0 1 4 190 6 0bcd 18 25 22 0 2 1 224 224 224 0 1
0 1 1 1 3 2 1 3 50 2 0222 16 27 22 121 150 136 224 224 224 0 1
0 1 1 1 31 7 1 0 1 0 0333 0 14 7 0 126 63 224 224 224 0 1
0 1 1 1 31 7 1 6 180 3 0444 29 47 38 356 511 434 224 224 224 0 1
0 1 1 1 0 0 1 7 40 2 0555 42 47 45 896 896 896 592 596 594 1 1
0 1 1 1 10 1 1 7 5 1 0666 41 47 44 896 896 896 512 564 538 1 1
1 1 1 1 20 0 1 7 3 0 0777 0 7 4 896 896 896 808 895 852 1 1
0 1 0 1 0 0 1 7 60 0 0888 42 47 45 160 160 160 224 224 224 0 1
0 1 1 0 0 0 1 7 191 0 0999 42 47 45 896 896 896 894 894 894 1 1
0 1 1 0 0 0 1 4 60 0 0aaa 24 31 28 160 160 160 224 224 224 0 0
0 0 1 1 0 0 1 7 40 2 0bbb 42 47 45 896 896 896 592 596 594 1 0
0 1 1 1 0 0 0 2 120 3 0ccc 12 19 16 0 0 0 224 224 224 0 0
1 1 1 1 0 0 0 7 77 4 0ddd 0 7 4 896 896 896 894 894 894 1 0
1 1 1 1 1 1 1 0 191 0 0eee 41 47 44 0 4 2 224 224 224 0 1
0 1 1 1 2 3 1 1 95 7 1234 3 16 10 245 280 263 224 224 224 0 1

/* sources.f */
common/gem_csc_pkg.sv
hw/gem_lut/pad_xky_lut.sv
hw/gem_lut/roll_wire_lut.sv
hw/cluster_match_ctrl.sv
hw/xky_window.sv
hw/wire_window.sv
hw/cluster_to_csc_top.sv
sim/cluster_to_csc_props.sv
sim/cluster_to_csc_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the cluster to csc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module cluster_to_csc_tb

sim_out=$(./obj_dir/Vcluster_to_csc_tb 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "Regression passed"; then
   exit 0
else
   exit 1
fi
